/* design/mem_pkg.sv */
// Shared sizes, data and address types, access-size enum for the data memory
package mem_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------
  localparam int BYTE_W = 8;                 // Bits per stored byte
  localparam int LANES  = 4;                 // Bytes moved per access
  localparam int ADDR_W = 14;                // Byte address width
  localparam int DEPTH  = 1 << ADDR_W;       // Bytes in the array
  localparam int DATA_W = LANES * BYTE_W;    // One full word
  localparam int HALF_W = 2 * BYTE_W;        // Halfword width

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  // Lane n holds the byte at addr + n
  typedef logic [DATA_W-1:0] data_t;

  typedef logic [ADDR_W-1:0] addr_t;         // Wraps at DEPTH

  // Per-lane write enable, bit n covers addr + n
  typedef logic [LANES-1:0] lane_mask_t;

  // Access size
  // Code 2'b11 is never legal on a request
  typedef enum logic [1:0] {
    SIZE_B = 2'b00,                          // Byte
    SIZE_H = 2'b01,                          // Halfword
    SIZE_W = 2'b10                           // Word
  } size_e;

endpackage

/* design/mem_if.sv */
// Interface for one lane-masked RAM access and its response
`timescale 1ns/100ps

interface mem_if import mem_pkg::*; ();

  // Request side, driven by the load/store unit
  logic       cs;       // Chip select
  logic       we;       // Write enable, wins over oe
  logic       oe;       // Output enable
  addr_t      addr;     // First byte of the access
  data_t      wdata;    // Lane-aligned store data
  lane_mask_t wmask;    // Lanes written on a store

  // Response side, driven by the RAM
  data_t      rdata;    // Registered read data
  logic       done;     // One-cycle end-of-access pulse

  // Load/store unit end
  modport lsu (
    output cs,
    output we,
    output oe,
    output addr,
    output wdata,
    output wmask,
    input  rdata,
    input  done
  );

  // RAM end
  modport ram (
    input  cs,
    input  we,
    input  oe,
    input  addr,
    input  wdata,
    input  wmask,
    output rdata,
    output done
  );

endinterface

/* design/byte_ram.sv */
// Byte-wide RAM with four-byte access, lane write enables, registered read and done
`timescale 1ns/100ps

module byte_ram import mem_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  mem_if.ram   mem
);

  // --------------------------------------------------
  // Storage and decode
  // --------------------------------------------------
  logic [BYTE_W-1:0] mem_array [DEPTH];   // One entry per byte

  addr_t lane_addr [LANES];               // Byte address per lane
  logic  wr_en;                           // Qualified store
  logic  rd_en;                           // Qualified load

  // Store wins over load when both are set
  assign wr_en = mem.cs && mem.we;
  assign rd_en = mem.cs && !mem.we && mem.oe;

  // Lane n hits addr + n
  // Sum truncates to ADDR_W so the top of the array wraps to 0
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_addr[i] = mem.addr + addr_t'(i);
    end
  end

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  // Only lanes with their mask bit set get written
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < LANES; i++) begin
        if (mem.wmask[i]) begin
          mem_array[lane_addr[i]] <= mem.wdata[i*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Lowest byte lands in bits 7:0
  // Held until the next load
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int i = 0; i < LANES; i++) begin
        mem.rdata[i*BYTE_W +: BYTE_W] <= mem_array[lane_addr[i]];
      end
    end
  end

  // --------------------------------------------------
  // Done pulse
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem.done <= 1'b0;
    end else begin
      mem.done <= wr_en || rd_en;         // High the cycle after the access
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Every store or load on the bus strobes ends with exactly one done cycle
  a_done_after_access : assert property (
    @(posedge clk) disable iff (!arst_n)
    (mem.cs && (mem.we || mem.oe)) |=> mem.done
  ) else $error("byte_ram: done missing after access");

  // Idle selects and deselected cycles never raise done
  a_no_stray_done : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(mem.cs && (mem.we || mem.oe)) |=> !mem.done
  ) else $error("byte_ram: done without an access");

  // A store from the LSU always writes at least one lane
  a_wmask_nonzero : assert property (
    @(posedge clk) disable iff (!arst_n)
    wr_en |-> (mem.wmask != '0)
  ) else $error("byte_ram: store with empty lane mask");

endmodule

/* design/load_store_unit.sv */
// Load/store unit that formats stores into lanes and masks and aligns and extends loads
`timescale 1ns/100ps

module load_store_unit import mem_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  req_cs,
  input  logic  req_we,
  input  logic  req_oe,
  input  addr_t req_addr,
  input  size_e req_size,
  input  logic  req_signed,
  input  data_t req_wdata,
  output data_t rsp_rdata,
  output logic  rsp_done,
  mem_if.lsu    mem
);

  // --------------------------------------------------
  // Internal signals
  // --------------------------------------------------
  data_t      st_data;     // Store data replicated into lanes
  lane_mask_t st_mask;     // Lanes touched by the store
  logic       ld_req;      // Request is a load this cycle

  size_e      ld_size;     // Size of the load in flight
  logic       ld_signed;   // Sign flag of the load in flight
  logic       ld_pend;     // Load response due this cycle

  data_t      ld_word;     // Extracted and extended load value
  data_t      rdata_q;     // Last completed load value

  assign ld_req = req_cs && !req_we && req_oe;

  // --------------------------------------------------
  // Store formatting
  // --------------------------------------------------

  // Access starts at req_addr itself so data always goes to the low lanes
  // The mask keeps copies in the upper lanes out of the array
  always_comb begin
    case (req_size)
      SIZE_B: begin
        st_data = {LANES{req_wdata[BYTE_W-1:0]}};
        st_mask = lane_mask_t'(1);                 // Lane 0
      end
      SIZE_H: begin
        st_data = {(LANES/2){req_wdata[HALF_W-1:0]}};
        st_mask = lane_mask_t'(3);                 // Lanes 0 and 1
      end
      default: begin
        st_data = req_wdata;                       // Word goes through as is
        st_mask = '1;
      end
    endcase
  end

  // Request goes straight through to the RAM
  assign mem.cs    = req_cs;
  assign mem.we    = req_we;
  assign mem.oe    = req_oe;
  assign mem.addr  = req_addr;
  assign mem.wdata = st_data;
  assign mem.wmask = st_mask;

  // --------------------------------------------------
  // Load tracking
  // --------------------------------------------------

  // Size and sign captured at the request edge
  // Used in the cycle the RAM returns data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ld_pend   <= 1'b0;
      ld_size   <= SIZE_B;
      ld_signed <= 1'b0;
    end else begin
      ld_pend <= ld_req;
      if (ld_req) begin
        ld_size   <= req_size;
        ld_signed <= req_signed;
      end
    end
  end

  // --------------------------------------------------
  // Load extraction
  // --------------------------------------------------

  // Wanted bytes sit in the lowest lanes
  always_comb begin
    case (ld_size)
      SIZE_B: ld_word = {{(DATA_W-BYTE_W){ld_signed & mem.rdata[BYTE_W-1]}},
                         mem.rdata[BYTE_W-1:0]};
      SIZE_H: ld_word = {{(DATA_W-HALF_W){ld_signed & mem.rdata[HALF_W-1]}},
                         mem.rdata[HALF_W-1:0]};
      default: ld_word = mem.rdata;                // Full word needs no extension
    endcase
  end

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  assign rsp_done = mem.done;                      // Stores and loads alike

  // Only a finished load updates the held value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata_q <= '0;
    end else if (mem.done && ld_pend) begin
      rdata_q <= ld_word;
    end
  end

  // Fresh load value shows in its own done cycle
  assign rsp_rdata = (mem.done && ld_pend) ? ld_word : rdata_q;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Illegal size code never accompanies a request
  a_legal_size : assert property (
    @(posedge clk) disable iff (!arst_n)
    req_cs |-> (req_size inside {SIZE_B, SIZE_H, SIZE_W})
  ) else $error("load_store_unit: illegal access size");

endmodule

/* design/data_mem_top.sv */
// Data memory top level, load/store unit joined to the byte RAM over mem_if
`timescale 1ns/100ps

module data_mem_top import mem_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,

  // Request strobes
  input  logic  req_cs,
  input  logic  req_we,
  input  logic  req_oe,
  input  addr_t req_addr,
  input  size_e req_size,
  input  logic  req_signed,
  input  data_t req_wdata,

  // Response
  output data_t rsp_rdata,
  output logic  rsp_done
);

  // --------------------------------------------------
  // Internal RAM bus
  // --------------------------------------------------
  mem_if mem_bus ();

  // --------------------------------------------------
  // Load/store unit
  // --------------------------------------------------

  // Turns sized requests into lane-masked accesses
  load_store_unit lsu_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_cs     (req_cs),
    .req_we     (req_we),
    .req_oe     (req_oe),
    .req_addr   (req_addr),
    .req_size   (req_size),
    .req_signed (req_signed),
    .req_wdata  (req_wdata),
    .rsp_rdata  (rsp_rdata),
    .rsp_done   (rsp_done),
    .mem        (mem_bus.lsu)
  );

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  byte_ram ram_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .mem    (mem_bus.ram)          // Registered read, done one cycle later
  );

endmodule

/* tb/tb_data_mem_top.sv */
// Testbench for the data memory with golden-file requests, response checks and timeout
`timescale 1ns/100ps

module tb_data_mem_top import mem_pkg::*; ();

  localparam int MAX_OPS = 256;            // Room for golden lines

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic  clk;
  logic  arst_n;
  logic  req_cs;
  logic  req_we;
  logic  req_oe;
  addr_t req_addr;
  size_e req_size;
  logic  req_signed;
  data_t req_wdata;
  data_t rsp_rdata;
  logic  rsp_done;

  // Golden table with one entry per access line
  logic [7:0] op_mem    [MAX_OPS];         // W, R or N
  size_e      size_mem  [MAX_OPS];
  logic       sign_mem  [MAX_OPS];
  addr_t      addr_mem  [MAX_OPS];
  data_t      wdata_mem [MAX_OPS];
  data_t      exp_mem   [MAX_OPS];         // Expected load value
  int         num_ops     = 0;

  int         cycle_cnt   = 0;             // Posedges since time 0
  int         cycle_limit = 0;             // Set once the table is known

  // Expectations per issued cycle with the oldest first
  logic       exp_done_q [$];
  logic       exp_load_q [$];
  data_t      exp_data_q [$];
  data_t      rdata_model;                 // Last completed load value

  // --------------------------------------------------
  // Clock and DUT
  // --------------------------------------------------
  initial clk = 1'b0;
  always #50 clk = ~clk;                   // 100 ns period

  data_mem_top data_mem_top_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_cs     (req_cs),
    .req_we     (req_we),
    .req_oe     (req_oe),
    .req_addr   (req_addr),
    .req_size   (req_size),
    .req_signed (req_signed),
    .req_wdata  (req_wdata),
    .rsp_rdata  (rsp_rdata),
    .rsp_done   (rsp_done)
  );

  // --------------------------------------------------
  // Failure handling and compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_data(input string name, input data_t exp_val, input data_t act_val);
    if (act_val !== exp_val) begin
      $display("Error: %s expected 0x%h actual 0x%h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_done(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("Error: %s expected 0x%h actual 0x%h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // Golden file reader
  // --------------------------------------------------

  // Lines that do not parse as six fields are comments
  task automatic load_golden();
    integer           fd;
    integer           n;
    logic [8*160-1:0] line_buf;
    logic [8*4-1:0]   op_tok;
    logic [1:0]       size_val;
    logic             sign_val;
    addr_t            addr_val;
    data_t            wdata_val;
    data_t            exp_val;
    fd = $fopen("tb/golden_mem_ops.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file tb/golden_mem_ops.txt");
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        if ($fgets(line_buf, fd) != 0) begin
          n = $sscanf(line_buf, "%s %h %h %h %h %h", op_tok, size_val, sign_val,
                      addr_val, wdata_val, exp_val);
          if (n == 6 && num_ops < MAX_OPS) begin
            op_mem[num_ops]    = op_tok[7:0];    // Single-letter op
            size_mem[num_ops]  = size_e'(size_val);
            sign_mem[num_ops]  = sign_val;
            addr_mem[num_ops]  = addr_val;
            wdata_mem[num_ops] = wdata_val;
            exp_mem[num_ops]   = exp_val;
            num_ops++;
          end
        end
      end
      $fclose(fd);
      if (num_ops == 0) begin
        $display("The golden file holds no accesses");
        abort_run();
      end
    end
  endtask

  // --------------------------------------------------
  // Request driving
  // --------------------------------------------------
  task automatic issue_request(input int idx);
    logic is_store;
    logic is_load;
    is_store = (op_mem[idx] == "W");
    is_load  = (op_mem[idx] == "R");
    if (!is_store && !is_load && op_mem[idx] != "N") begin
      $display("Unknown operation on golden access %0d", idx + 1);
      abort_run();
    end
    req_cs     <= 1'b1;                    // N gives cs with we and oe low
    req_we     <= is_store;
    req_oe     <= is_load;
    req_addr   <= addr_mem[idx];
    req_size   <= size_mem[idx];
    req_signed <= sign_mem[idx];
    req_wdata  <= wdata_mem[idx];
    exp_done_q.push_back(is_store || is_load);
    exp_load_q.push_back(is_load);
    exp_data_q.push_back(exp_mem[idx]);
  endtask

  task automatic drive_idle();
    req_cs <= 1'b0;
    req_we <= 1'b0;
    req_oe <= 1'b0;
    exp_done_q.push_back(1'b0);
    exp_load_q.push_back(1'b0);
    exp_data_q.push_back('0);
  endtask

  // Front entry was sampled at the last edge and its response is due now
  // A load value comes out together with its done
  task automatic verify_response();
    check_done("rsp_done", exp_done_q[0], rsp_done);
    if (exp_load_q[0]) begin
      rdata_model = exp_data_q[0];
    end
    check_data("rsp_rdata", rdata_model, rsp_rdata);  // Holds across stores and idles
    void'(exp_done_q.pop_front());
    void'(exp_load_q.pop_front());
    void'(exp_data_q.pop_front());
  endtask

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles without finishing the golden accesses", cycle_cnt);
      abort_run();
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : run_tests
    req_cs      = 1'b0;
    req_we      = 1'b0;
    req_oe      = 1'b0;
    req_addr    = '0;
    req_size    = SIZE_W;
    req_signed  = 1'b0;
    req_wdata   = '0;
    arst_n      = 1'b0;
    rdata_model = '0;                      // rsp_rdata value after reset

    load_golden();
    cycle_limit = 2 * num_ops + 20;

    // Nothing is due in the first cycle after reset
    exp_done_q.push_back(1'b0);
    exp_load_q.push_back(1'b0);
    exp_data_q.push_back('0);

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    // One request per cycle and a trailing idle for the last response
    for (int i = 0; i < num_ops + 1; i++) begin
      @(posedge clk);
      if (i < num_ops) begin
        issue_request(i);
      end else begin
        drive_idle();
      end
      @(negedge clk);                      // Outputs settled mid-cycle
      verify_response();
    end

    $display("all tests passed");
    $finish;
  end

endmodule

/* build.f */
design/mem_pkg.sv
design/mem_if.sv
design/byte_ram.sv
design/load_store_unit.sv
design/data_mem_top.sv
tb/tb_data_mem_top.sv

/* tb/golden_mem_ops.txt */
# op size signed addr wdata expected, all hex
# op W store, R load, N select with we and oe low; size 0 byte, 1 half, 2 word
# word store then load
W 2 0 0010 11223344 00000000
R 2 0 0010 00000000 11223344
W 2 0 0020 deadbeef 00000000
W 2 0 0024 01234567 00000000
R 2 0 0020 00000000 deadbeef
R 2 0 0024 00000000 01234567
R 2 0 0022 00000000 4567dead
# sub-word stores keep neighbouring bytes
W 0 0 0021 123456a5 00000000
R 2 0 0020 00000000 deada5ef
W 1 0 0026 9abc7e81 00000000
R 2 0 0024 00000000 7e814567
W 0 0 0013 fffffff0 00000000
R 2 0 0010 00000000 f0223344
W 1 0 0011 0000beef 00000000
R 2 0 0010 00000000 f0beef44
# sign and zero extension
R 0 0 0011 00000000 000000ef
R 0 1 0011 00000000 ffffffef
R 0 1 0010 00000000 00000044
R 0 0 0024 00000000 00000067
R 0 1 0021 00000000 ffffffa5
R 1 0 0011 00000000 0000beef
R 1 1 0011 00000000 ffffbeef
R 1 1 0025 00000000 ffff8145
R 1 0 0025 00000000 00008145
R 1 1 0026 00000000 00007e81
R 0 1 0027 00000000 0000007e
W 0 0 0030 00000080 00000000
R 0 1 0030 00000000 ffffff80
R 0 0 0030 00000000 00000080
W 1 0 0032 00008001 00000000
R 1 1 0032 00000000 ffff8001
R 1 0 0032 00000000 00008001
# unaligned words and wrap at the top of the array
W 2 0 0041 a1b2c3d4 00000000
R 2 0 0041 00000000 a1b2c3d4
R 0 0 0043 00000000 000000b2
R 1 1 0042 00000000 ffffb2c3
W 2 0 3ffe 55667788 00000000
R 2 0 3ffe 00000000 55667788
R 1 0 0000 00000000 00005566
W 1 0 0002 0000c0de 00000000
R 2 0 0000 00000000 c0de5566
R 1 1 3fff 00000000 00006677
W 0 0 3fff 000000f1 00000000
R 2 0 3ffe 00000000 5566f188
R 0 1 3fff 00000000 fffffff1
# idle selects give no done, load right after store
N 0 0 0010 00000000 00000000
N 2 0 0020 00000000 00000000
R 2 0 0024 00000000 7e814567
N 0 0 0000 00000000 00000000
W 2 0 0050 cafef00d 00000000
R 2 0 0050 00000000 cafef00d
W 0 0 0052 00000011 00000000
R 2 0 0050 00000000 ca11f00d
N 2 0 0050 00000000 00000000
N 2 0 0050 00000000 00000000
R 0 1 0051 00000000 fffffff0
